// ==== list.f ====
+incdir+include
logic/rv_types_pkg.sv
logic/fetch_pc_unit.sv
logic/compressed_expander.sv
logic/pipeline_stage_reg.sv
logic/instr_decoder.sv
logic/issue_credit_gate.sv
logic/fetch_decode_top.sv
verif/fetch_decode_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= fetch_decode_tb
FLIST     ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== verif/fetch_decode_tb.sv ====
`timescale 1ns/100ps

`include "rv_macros.svh"

module fetch_decode_tb;
    import rv_types_pkg::*;

    localparam int MAX_ROWS   = 20;
    localparam int TARGET_ROW = 16;             // First row of the redirect target path
    localparam int WAIT_LIMIT = 50;             // Cycles allowed per issue wait

    logic         i_clock;
    logic         i_reset;
    inst_t        i_imem_data;
    logic         i_redirect;
    inst_addr_t   i_redirect_pc;
    logic         i_credit_return;
    inst_addr_t   o_imem_addr;
    logic         o_issue_valid;
    inst_addr_t   o_issue_pc;
    inst_t        o_issue_inst;
    logic         o_issue_compressed;
    inst_format_t o_issue_format;
    reg_idx_t     o_issue_rd;
    reg_idx_t     o_issue_rs1;
    reg_idx_t     o_issue_rs2;
    logic [31:0]  o_issue_imm;

    logic [15:0]  rom [0:511];                  // Halfword wide instruction memory
    logic [8:0]   half_idx;

    inst_addr_t   row_addr [MAX_ROWS];
    inst_t        row_enc [MAX_ROWS];           // Raw memory encoding
    inst_t        row_exp [MAX_ROWS];           // Expected expanded instruction
    logic         row_c [MAX_ROWS];
    inst_format_t row_fmt [MAX_ROWS];
    reg_idx_t     row_rd [MAX_ROWS];
    reg_idx_t     row_rs1 [MAX_ROWS];
    reg_idx_t     row_rs2 [MAX_ROWS];
    logic [31:0]  row_imm [MAX_ROWS];

    int           n_rows;
    int           idx;
    int           errors;
    int           credits_model;
    integer       seed;
    logic         issued_now;
    logic         got;

    fetch_decode_top dut (
        .i_clock(i_clock), .i_reset(i_reset), .i_imem_data(i_imem_data),
        .i_redirect(i_redirect), .i_redirect_pc(i_redirect_pc),
        .i_credit_return(i_credit_return), .o_imem_addr(o_imem_addr),
        .o_issue_valid(o_issue_valid), .o_issue_pc(o_issue_pc),
        .o_issue_inst(o_issue_inst), .o_issue_compressed(o_issue_compressed),
        .o_issue_format(o_issue_format), .o_issue_rd(o_issue_rd),
        .o_issue_rs1(o_issue_rs1), .o_issue_rs2(o_issue_rs2), .o_issue_imm(o_issue_imm));

    always #10 i_clock = ~i_clock;

    // Any halfword address gives a 32 bit window
    assign half_idx    = o_imem_addr[9:1];
    assign i_imem_data = {rom[half_idx + 9'd1], rom[half_idx]};

    task automatic add_row(input inst_addr_t addr, input inst_t enc, input inst_t exp_inst,
                           input logic c, input inst_format_t fmt, input reg_idx_t rd,
                           input reg_idx_t rs1, input reg_idx_t rs2, input logic [31:0] imm);
        row_addr[n_rows] = addr;
        row_enc[n_rows]  = enc;
        row_exp[n_rows]  = exp_inst;
        row_c[n_rows]    = c;
        row_fmt[n_rows]  = fmt;
        row_rd[n_rows]   = rd;
        row_rs1[n_rows]  = rs1;
        row_rs2[n_rows]  = rs2;
        row_imm[n_rows]  = imm;
        n_rows++;
    endtask

    task automatic build_table();
        // Sequential path from reset
        add_row('h00, 'hFFB00093, 'hFFB00093, 1'b0, FMT_I, 1, 0, 0, 'hFFFFFFFB);  // ADDI -5
        add_row('h04, 'h002081B3, 'h002081B3, 1'b0, FMT_R, 3, 1, 2, 0);  // ADD
        add_row('h08, 'h1475, 'hFFD40413, 1'b1, FMT_I, 8, 8, 0, 'hFFFFFFFD);  // C.ADDI -3
        add_row('h0A, 'h429D, 'h00700293, 1'b1, FMT_I, 5, 0, 0, 7);  // C.LI 7
        add_row('h0C, 'hFE21AC23, 'hFE21AC23, 1'b0, FMT_S, 0, 3, 2, 'hFFFFFFF8);  // SW -8
        add_row('h10, 'h852E, 'h00B00533, 1'b1, FMT_R, 10, 0, 11, 0);  // C.MV
        add_row('h12, 'hFE2088E3, 'hFE2088E3, 1'b0, FMT_B, 0, 1, 2, 'hFFFFFFF0);  // BEQ -16
        add_row('h16, 'h9636, 'h00D60633, 1'b1, FMT_R, 12, 12, 13, 0);  // C.ADD
        add_row('h18, 'hABCDE3B7, 'hABCDE3B7, 1'b0, FMT_U, 7, 0, 0, 'hABCDE000);  // LUI
        add_row('h1C, 'h4144, 'h00452483, 1'b1, FMT_I, 9, 10, 0, 4);  // C.LW
        add_row('h1E, 'hC60C, 'h00B62423, 1'b1, FMT_S, 0, 12, 11, 8);  // C.SW
        add_row('h20, 'hA801, 'h0100006F, 1'b1, FMT_J, 0, 0, 0, 16);  // C.J +16
        add_row('h22, 'h8082, 'h00000013, 1'b1, FMT_ILLEGAL, 0, 0, 0, 0);  // C.JR unsupported
        add_row('h24, 'h0001, 'h00000013, 1'b1, FMT_I, 0, 0, 0, 0);  // C.NOP
        add_row('h26, 'hFF9FF0EF, 'hFF9FF0EF, 1'b0, FMT_J, 1, 0, 0, 'hFFFFFFF8);  // JAL -8
        add_row('h2A, 'h12345217, 'h12345217, 1'b0, FMT_U, 4, 0, 0, 'h12345000);  // AUIPC
        // Redirect target path
        add_row('h100, 'h407302B3, 'h407302B3, 1'b0, FMT_R, 5, 6, 7, 0);  // SUB
        add_row('h104, 'h5781, 'hFE000793, 1'b1, FMT_I, 15, 0, 0, 'hFFFFFFE0);  // C.LI -32
        add_row('h106, 'h0086, 'h00000013, 1'b1, FMT_ILLEGAL, 0, 0, 0, 0);  // C.SLLI unsupported
        add_row('h108, 'hFFC12403, 'hFFC12403, 1'b0, FMT_I, 8, 2, 0, 'hFFFFFFFC);  // LW -4
    endtask

    task automatic load_rom();
        int         i;
        logic [8:0] h;
        for (i = 0; i < 512; i++)
            rom[i] = {i[8:0], 7'b0010011};      // OP-IMM halfword tagged with its index
        for (i = 0; i < n_rows; i++)
        begin
            h      = row_addr[i][9:1];
            rom[h] = row_enc[i][15:0];
            if (!row_c[i])
                rom[h + 9'd1] = row_enc[i][31:16];
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got_val,
                               input logic [31:0] exp_val);
        if (got_val !== exp_val)
        begin
            errors++;
            $display("Error at %0t: %s is %h, expected %h", $time, name, got_val, exp_val);
        end
    endtask

    task automatic check_row(input int r);
        check_value("o_issue_pc", o_issue_pc, row_addr[r]);
        check_value("o_issue_inst", o_issue_inst, row_exp[r]);
        check_value("o_issue_compressed", 32'(o_issue_compressed), 32'(row_c[r]));
        check_value("o_issue_format", 32'(o_issue_format), 32'(row_fmt[r]));
        check_value("o_issue_rd", 32'(o_issue_rd), 32'(row_rd[r]));
        check_value("o_issue_rs1", 32'(o_issue_rs1), 32'(row_rs1[r]));
        check_value("o_issue_rs2", 32'(o_issue_rs2), 32'(row_rs2[r]));
        check_value("o_issue_imm", o_issue_imm, row_imm[r]);
    endtask

    // Drives inputs after the rising edge and samples at the falling edge
    task automatic step_cycle(input logic ret, input logic redir);
        @(posedge i_clock);
        #2;
        i_credit_return = ret;
        i_redirect      = redir;
        @(negedge i_clock);
        issued_now = o_issue_valid;
        if (issued_now && credits_model == 0)
        begin
            errors++;
            $display("Instruction issued with no credit left at %0t", $time);
        end
        if (issued_now && !ret)
            credits_model--;
        else if (!issued_now && ret && credits_model < `ISSUE_CREDITS)
            credits_model++;
    endtask

    task automatic next_issue(input logic use_random, output logic found);
        int   n;
        logic ret;
        found = 1'b0;
        for (n = 0; n < WAIT_LIMIT && !found; n++)
        begin
            ret = use_random ? (($random(seed) % 2) != 0) : 1'b0;
            step_cycle(ret, 1'b0);
            found = issued_now;
        end
        if (!found)
        begin
            errors++;
            $display("Timeout: table row %0d did not issue within %0d cycles", idx, WAIT_LIMIT);
        end
    endtask

    task automatic finish_run();
        $display("Run finished with %0d errors", errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    endtask

    initial
    begin
        i_clock         = 1'b0;
        i_reset         = 1'b1;
        i_redirect      = 1'b0;
        i_redirect_pc   = inst_addr_t'('h100);
        i_credit_return = 1'b0;
        n_rows          = 0;
        idx             = 0;
        errors          = 0;
        credits_model   = `ISSUE_CREDITS;
        seed            = 46105;
        issued_now      = 1'b0;
        build_table();
        load_rom();
        repeat (2) @(posedge i_clock);
        #2 i_reset = 1'b0;

        begin : run
            // Only the initial credits may issue while returns are withheld
            while (idx < `ISSUE_CREDITS)
            begin
                next_issue(1'b0, got);
                if (!got)
                    disable run;
                check_row(idx);
                idx++;
            end
            repeat (10) step_cycle(1'b0, 1'b0);   // Must stay stalled

            while (idx < 8)
            begin
                next_issue(1'b1, got);
                if (!got)
                    disable run;
                check_row(idx);
                idx++;
            end

            // Drain the credits so the redirect hits a stalled pipeline
            while (credits_model != 0)
            begin
                next_issue(1'b0, got);
                if (!got)
                    disable run;
                check_row(idx);
                idx++;
            end
            repeat (4) step_cycle(1'b0, 1'b0);
            step_cycle(1'b0, 1'b1);
            step_cycle(1'b0, 1'b0);
            check_value("o_imem_addr", o_imem_addr, row_addr[TARGET_ROW]);  // Target fetch
            idx = TARGET_ROW;

            while (idx < n_rows)
            begin
                next_issue(1'b1, got);
                if (!got)
                    disable run;
                check_row(idx);
                idx++;
            end
        end
        finish_run();
    end

endmodule

// ==== logic/fetch_decode_top.sv ====
`timescale 1ns/100ps

module fetch_decode_top (
    input  logic                       i_clock,
    input  logic                       i_reset,
    input  rv_types_pkg::inst_t        i_imem_data,     // Same cycle read
    input  logic                       i_redirect,
    input  rv_types_pkg::inst_addr_t   i_redirect_pc,
    input  logic                       i_credit_return,
    output rv_types_pkg::inst_addr_t   o_imem_addr,
    output logic                       o_issue_valid,
    output rv_types_pkg::inst_addr_t   o_issue_pc,
    output rv_types_pkg::inst_t        o_issue_inst,
    output logic                       o_issue_compressed,
    output rv_types_pkg::inst_format_t o_issue_format,
    output rv_types_pkg::reg_idx_t     o_issue_rd,
    output rv_types_pkg::reg_idx_t     o_issue_rs1,
    output rv_types_pkg::reg_idx_t     o_issue_rs2,
    output logic [31:0]                o_issue_imm
);
    import rv_types_pkg::*;

    inst_addr_t      fetch_pc;
    logic            fetch_valid;
    inst_t           exp_inst;
    logic            exp_compressed;
    logic            exp_illegal;
    fetch_payload_t  if_id_in;
    fetch_payload_t  if_id_out;
    logic            if_id_valid;
    decode_payload_t dec_out;
    decode_payload_t id_ex_out;
    logic            id_ex_valid;
    logic            stall;

    fetch_pc_unit pc_unit (
        .i_clock(i_clock), .i_reset(i_reset), .i_stall(stall),
        .i_redirect(i_redirect), .i_redirect_pc(i_redirect_pc),
        .i_compressed(exp_compressed), .o_pc(fetch_pc), .o_valid(fetch_valid));

    compressed_expander expander (
        .i_raw(i_imem_data), .o_inst(exp_inst),
        .o_compressed(exp_compressed), .o_illegal(exp_illegal));

    assign if_id_in = '{pc: fetch_pc, inst: exp_inst,
                        compressed: exp_compressed, illegal: exp_illegal};

    pipeline_stage_reg #(.T_PAYLOAD(fetch_payload_t)) if_id (
        .i_clock(i_clock), .i_reset(i_reset), .i_flush(i_redirect), .i_stall(stall),
        .i_valid(fetch_valid), .i_payload(if_id_in),
        .o_valid(if_id_valid), .o_payload(if_id_out));

    instr_decoder decoder (.i_payload(if_id_out), .o_payload(dec_out));

    pipeline_stage_reg #(.T_PAYLOAD(decode_payload_t)) id_ex (
        .i_clock(i_clock), .i_reset(i_reset), .i_flush(i_redirect), .i_stall(stall),
        .i_valid(if_id_valid), .i_payload(dec_out),
        .o_valid(id_ex_valid), .o_payload(id_ex_out));

    issue_credit_gate credit_gate (
        .i_clock(i_clock), .i_reset(i_reset), .i_valid(id_ex_valid),
        .i_credit_return(i_credit_return),
        .o_issue_valid(o_issue_valid), .o_stall(stall));

    assign o_imem_addr        = fetch_pc;
    assign o_issue_pc         = id_ex_out.pc;
    assign o_issue_inst       = id_ex_out.inst;
    assign o_issue_compressed = id_ex_out.compressed;
    assign o_issue_format     = id_ex_out.format;
    assign o_issue_rd         = id_ex_out.rd;
    assign o_issue_rs1        = id_ex_out.rs1;
    assign o_issue_rs2        = id_ex_out.rs2;
    assign o_issue_imm        = id_ex_out.imm;

endmodule

// ==== logic/issue_credit_gate.sv ====
`timescale 1ns/100ps

`include "rv_macros.svh"

module issue_credit_gate (
    input  logic i_clock,
    input  logic i_reset,
    input  logic i_valid,           // ID/EX holds an instruction
    input  logic i_credit_return,   // One slot freed downstream
    output logic o_issue_valid,
    output logic o_stall            // Freeze the whole front end
);

    typedef logic [`CREDIT_WIDTH-1:0] credit_cnt_t;

    localparam credit_cnt_t MAX_CREDITS = credit_cnt_t'(`ISSUE_CREDITS);

    credit_cnt_t credits;
    logic        has_credit;

    assign has_credit    = (credits != '0);
    assign o_issue_valid = i_valid && has_credit;
    assign o_stall       = i_valid && !has_credit;

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            credits <= MAX_CREDITS;
        else
        begin
            case ({o_issue_valid, i_credit_return})
                2'b10:
                    credits <= credits - 1'b1;      // Issue only
                2'b01:
                begin
                    if (credits != MAX_CREDITS)     // Never above buffer depth
                        credits <= credits + 1'b1;
                end
                default: ;                          // Both or neither
            endcase
        end
    end

endmodule

// ==== logic/instr_decoder.sv ====
`timescale 1ns/100ps

module instr_decoder (
    input  rv_types_pkg::fetch_payload_t  i_payload,
    output rv_types_pkg::decode_payload_t o_payload
);
    import rv_types_pkg::*;

    inst_t        inst;
    inst_format_t format;
    logic [31:0]  imm;
    reg_idx_t     rd;
    reg_idx_t     rs1;
    reg_idx_t     rs2;

    assign inst = i_payload.inst;

    always_comb
    begin
        if (i_payload.illegal)
            format = FMT_ILLEGAL;
        else
        begin
            case (inst[6:0])
                OPC_OP:                          format = FMT_R;
                OPC_OP_IMM, OPC_LOAD, OPC_JALR:  format = FMT_I;
                OPC_MISC_MEM, OPC_SYSTEM:        format = FMT_I;
                OPC_STORE:                       format = FMT_S;
                OPC_BRANCH:                      format = FMT_B;
                OPC_LUI, OPC_AUIPC:              format = FMT_U;
                OPC_JAL:                         format = FMT_J;
                default:                         format = FMT_ILLEGAL;
            endcase
        end
    end

    always_comb
    begin
        case (format)
            FMT_I:   imm = {{20{inst[31]}}, inst[31:20]};
            FMT_S:   imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            FMT_B:   imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            FMT_U:   imm = {inst[31:12], 12'd0};
            FMT_J:   imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            default: imm = 32'd0;               // R and illegal
        endcase
    end

    // Only the register fields the format really has are passed on
    always_comb
    begin
        rd  = inst[11:7];
        rs1 = inst[19:15];
        rs2 = inst[24:20];
        case (format)
            FMT_R:        ;
            FMT_I:        rs2 = 5'd0;
            FMT_S, FMT_B: rd  = 5'd0;
            FMT_U, FMT_J:
            begin
                rs1 = 5'd0;
                rs2 = 5'd0;
            end
            default:
            begin
                rd  = 5'd0;
                rs1 = 5'd0;
                rs2 = 5'd0;
            end
        endcase
    end

    assign o_payload = '{pc: i_payload.pc, inst: inst, compressed: i_payload.compressed,
                         format: format, rd: rd, rs1: rs1, rs2: rs2, imm: imm};

endmodule

// ==== logic/pipeline_stage_reg.sv ====
`timescale 1ns/100ps

module pipeline_stage_reg #(
    parameter type T_PAYLOAD = logic [31:0]
) (
    input  logic     i_clock,
    input  logic     i_reset,
    input  logic     i_flush,       // Drop the held entry
    input  logic     i_stall,       // Keep the held entry
    input  logic     i_valid,
    input  T_PAYLOAD i_payload,
    output logic     o_valid,
    output T_PAYLOAD o_payload
);

    // Flush takes priority over stall so a redirect is never lost
    always_ff @(posedge i_clock)
    begin
        if (i_reset || i_flush)
        begin
            o_valid   <= 1'b0;
            o_payload <= '0;
        end
        else if (!i_stall)
        begin
            o_valid   <= i_valid;
            o_payload <= i_payload;
        end
    end

endmodule

// ==== logic/compressed_expander.sv ====
`timescale 1ns/100ps

module compressed_expander (
    input  rv_types_pkg::inst_t i_raw,          // Low halfword is the instruction
    output rv_types_pkg::inst_t o_inst,         // 32 bit form
    output logic                o_compressed,
    output logic                o_illegal       // Unsupported compressed form
);
    import rv_types_pkg::*;

    logic        compressed;
    logic [1:0]  quadrant;
    logic [2:0]  funct3;
    reg_idx_t    rd_full;                       // CI/CR register fields
    reg_idx_t    rs2_full;
    reg_idx_t    rd_prime;                      // CL/CS registers x8..x15
    reg_idx_t    rs1_prime;
    logic [11:0] ci_imm;
    logic [11:0] mem_off;
    logic [20:0] j_off;

    assign compressed = (i_raw[1:0] != 2'b11);
    assign quadrant   = i_raw[1:0];
    assign funct3     = i_raw[15:13];
    assign rd_full    = i_raw[11:7];
    assign rs2_full   = i_raw[6:2];
    assign rd_prime   = {2'b01, i_raw[4:2]};
    assign rs1_prime  = {2'b01, i_raw[9:7]};

    assign ci_imm  = {{6{i_raw[12]}}, i_raw[12], i_raw[6:2]};
    assign mem_off = {5'd0, i_raw[5], i_raw[12:10], i_raw[6], 2'b00};  // Word scaled

    // C.J offset bits are scrambled in the encoding
    assign j_off = {{9{i_raw[12]}}, i_raw[12], i_raw[8], i_raw[10:9], i_raw[6],
                    i_raw[7], i_raw[2], i_raw[11], i_raw[5:3], 1'b0};

    always_comb
    begin
        o_inst    = INST_NOP;
        o_illegal = 1'b0;
        if (!compressed)
            o_inst = i_raw;                     // Already full size
        else
        begin
            case ({quadrant, funct3})
                5'b01_000: // C.ADDI, C.NOP when rd is x0
                    o_inst = {ci_imm, rd_full, 3'b000, rd_full, OPC_OP_IMM};
                5'b01_010: // C.LI
                    o_inst = {ci_imm, 5'd0, 3'b000, rd_full, OPC_OP_IMM};
                5'b01_101: // C.J
                    o_inst = {j_off[20], j_off[10:1], j_off[11], j_off[19:12],
                              5'd0, OPC_JAL};
                5'b00_010: // C.LW
                    o_inst = {mem_off, rs1_prime, 3'b010, rd_prime, OPC_LOAD};
                5'b00_110: // C.SW
                    o_inst = {mem_off[11:5], rd_prime, rs1_prime, 3'b010,
                              mem_off[4:0], OPC_STORE};
                5'b10_100:
                begin
                    if (rs2_full == 5'd0)
                        o_illegal = 1'b1;       // C.JR, C.JALR, C.EBREAK
                    else if (i_raw[12])
                        o_inst = {7'd0, rs2_full, rd_full, 3'b000, rd_full, OPC_OP};
                    else
                        o_inst = {7'd0, rs2_full, 5'd0, 3'b000, rd_full, OPC_OP};
                end
                default:
                    o_illegal = 1'b1;
            endcase
        end
    end

    assign o_compressed = compressed;

endmodule

// ==== logic/fetch_pc_unit.sv ====
`timescale 1ns/100ps

`include "rv_macros.svh"

module fetch_pc_unit (
    input  logic                     i_clock,
    input  logic                     i_reset,
    input  logic                     i_stall,        // Hold the current fetch
    input  logic                     i_redirect,     // Load new target
    input  rv_types_pkg::inst_addr_t i_redirect_pc,
    input  logic                     i_compressed,   // Fetched instruction is 16 bit
    output rv_types_pkg::inst_addr_t o_pc,
    output logic                     o_valid
);
    import rv_types_pkg::*;

    inst_addr_t pc;
    inst_addr_t step;
    logic       running;

    assign step = i_compressed ? inst_addr_t'(2) : inst_addr_t'(4);

    // First cycle out of reset is a bubble and the PC only starts walking
    // once the fetch is marked valid
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            pc      <= inst_addr_t'(`RESET_PC);
            running <= 1'b0;
        end
        else if (i_redirect)
        begin
            pc      <= i_redirect_pc;   // Wins over a stall
            running <= 1'b1;
        end
        else if (!running)
        begin
            running <= 1'b1;            // Fetch RESET_PC next cycle
        end
        else if (!i_stall)
        begin
            pc <= pc + step;            // Sequential step
        end
    end

    assign o_pc    = pc;
    assign o_valid = running;

endmodule

// ==== logic/rv_types_pkg.sv ====
`include "rv_macros.svh"

package rv_types_pkg;

    typedef logic [`ADDR_WIDTH-1:0] inst_addr_t;  // Instruction address
    typedef logic [31:0]            inst_t;       // Full size instruction word
    typedef logic [4:0]             reg_idx_t;    // Register index
    typedef logic [6:0]             opcode_t;

    typedef enum logic [2:0] {
        FMT_R,
        FMT_I,
        FMT_S,
        FMT_B,
        FMT_U,
        FMT_J,
        FMT_ILLEGAL
    } inst_format_t;

    // RV32I base opcodes
    localparam opcode_t OPC_LOAD     = 7'b0000011;
    localparam opcode_t OPC_MISC_MEM = 7'b0001111;
    localparam opcode_t OPC_OP_IMM   = 7'b0010011;
    localparam opcode_t OPC_AUIPC    = 7'b0010111;
    localparam opcode_t OPC_STORE    = 7'b0100011;
    localparam opcode_t OPC_OP       = 7'b0110011;
    localparam opcode_t OPC_LUI      = 7'b0110111;
    localparam opcode_t OPC_BRANCH   = 7'b1100011;
    localparam opcode_t OPC_JALR     = 7'b1100111;
    localparam opcode_t OPC_JAL      = 7'b1101111;
    localparam opcode_t OPC_SYSTEM   = 7'b1110011;

    localparam inst_t INST_NOP = 32'h0000_0013;   // ADDI x0, x0, 0

    typedef struct packed {
        inst_addr_t pc;
        inst_t      inst;        // Already expanded
        logic       compressed;
        logic       illegal;
    } fetch_payload_t;

    typedef struct packed {
        inst_addr_t   pc;
        inst_t        inst;
        logic         compressed;
        inst_format_t format;
        reg_idx_t     rd;
        reg_idx_t     rs1;
        reg_idx_t     rs2;
        logic [31:0]  imm;       // Sign extended
    } decode_payload_t;

endpackage

// ==== include/rv_macros.svh ====
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// Fetch address space

// Instruction address width in bits
`define ADDR_WIDTH 32

// First fetch address after reset
`define RESET_PC 'h0000_0000

// Issue flow control

// Credits after reset match the depth of the execute input buffer
`define ISSUE_CREDITS 4

// Wide enough to hold ISSUE_CREDITS
`define CREDIT_WIDTH 3

`endif
